//--- hdl/xbar_pkg.sv
package xbar_pkg;

  //------------------------------------------------------------
  // channel buffer geometry
  //------------------------------------------------------------
  localparam int NUM_ENTRIES = 5;
  localparam int NUM_BANKS   = 4;
  localparam int ENTRY_ID_W  = 3;   // enough for 0..NUM_ENTRIES-1

  //------------------------------------------------------------
  // request payload
  //------------------------------------------------------------
  localparam int OP_W        = 2;
  localparam int LINE_ADDR_W = 28;  // byte address bits 31..4
  localparam int BANK_SEL_W  = 2;   // address bits 9..8
  localparam int SET_W       = 4;   // address bits 7..4
  localparam int TAG_W       = LINE_ADDR_W - BANK_SEL_W - SET_W;

  typedef logic [ENTRY_ID_W-1:0]  entry_id_t;
  typedef logic [NUM_ENTRIES-1:0] entry_mask_t;  // one bit per entry
  typedef logic [OP_W-1:0]        op_t;
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;

  // same 28 bits, read as a whole or split into fields
  typedef union packed {
    line_addr_t line;
    struct packed {
      logic [TAG_W-1:0]      tag;      // bits 31..10
      logic [BANK_SEL_W-1:0] bank;     // bits 9..8
      logic [SET_W-1:0]      set_idx;  // bits 7..4
    } fld;
  } line_addr_u;

endpackage

//--- hdl/ch_entry_store.sv
`timescale 1ns/10ps

module ch_entry_store (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              req_valid_i,
  input  xbar_pkg::op_t                                     req_op_i,
  input  xbar_pkg::line_addr_t                              req_addr_i,
  input  logic                                              ready_i,
  output logic                                              accept_o,
  output logic [xbar_pkg::NUM_BANKS-1:0]                    alloc_o,
  output xbar_pkg::entry_mask_t                             wr_ptr_oh_o,
  output xbar_pkg::op_t        [xbar_pkg::NUM_ENTRIES-1:0]  ent_op_o,
  output xbar_pkg::line_addr_t [xbar_pkg::NUM_ENTRIES-1:0]  ent_addr_o
);

  logic                                               accept;
  xbar_pkg::entry_id_t                                wr_ptr_q;
  xbar_pkg::entry_mask_t                              wr_ptr_oh;
  xbar_pkg::line_addr_u                               req_addr_u;
  logic [xbar_pkg::NUM_BANKS-1:0]                     bank_oh;
  xbar_pkg::op_t        [xbar_pkg::NUM_ENTRIES-1:0]   ent_op_q;
  xbar_pkg::line_addr_t [xbar_pkg::NUM_ENTRIES-1:0]   ent_addr_q;

  //------------------------------------------------------------
  // accept and write pointer
  //------------------------------------------------------------
  assign accept   = req_valid_i & ready_i;
  assign accept_o = accept;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
    end else if (accept) begin
      if (wr_ptr_q == xbar_pkg::entry_id_t'(xbar_pkg::NUM_ENTRIES - 1)) begin
        wr_ptr_q <= '0;  // wrap
      end else begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < xbar_pkg::NUM_ENTRIES; i++) begin
      wr_ptr_oh[i] = (wr_ptr_q == xbar_pkg::entry_id_t'(i));
    end
  end

  assign wr_ptr_oh_o = wr_ptr_oh;

  //------------------------------------------------------------
  // bank steering from address bits 9..8
  //------------------------------------------------------------
  assign req_addr_u.line = req_addr_i;

  always_comb begin
    bank_oh = '0;
    bank_oh[req_addr_u.fld.bank] = 1'b1;
  end

  assign alloc_o = accept ? bank_oh : '0;  // only in the accept cycle

  //------------------------------------------------------------
  // op / address entry arrays
  //------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < xbar_pkg::NUM_ENTRIES; i++) begin
      if (accept && wr_ptr_oh[i]) begin
        ent_op_q[i]   <= req_op_i;
        ent_addr_q[i] <= req_addr_u.line;
      end
    end
  end

  assign ent_op_o   = ent_op_q;
  assign ent_addr_o = ent_addr_q;

  // a stalled request keeps its payload until accepted
  a_stall_holds_req : assert property (
    @(posedge clk_i) disable iff (rst_i)
    req_valid_i && !ready_i |=>
      req_valid_i && $stable(req_op_i) && $stable(req_addr_i)
  );

endmodule

//--- hdl/ch_bank_lane.sv
`timescale 1ns/10ps

module ch_bank_lane (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              alloc_i,
  input  xbar_pkg::entry_mask_t                             wr_ptr_oh_i,
  input  xbar_pkg::entry_id_t                               rd_ptr_i,
  input  xbar_pkg::op_t        [xbar_pkg::NUM_ENTRIES-1:0]  ent_op_i,
  input  xbar_pkg::line_addr_t [xbar_pkg::NUM_ENTRIES-1:0]  ent_addr_i,
  input  logic                                              gnt_i,
  output logic                                              req_o,
  output xbar_pkg::op_t                                     op_o,
  output xbar_pkg::line_addr_t                              addr_o,
  output logic                                              head_valid_o
);

  xbar_pkg::entry_mask_t valid_q;
  xbar_pkg::entry_mask_t valid_d;
  xbar_pkg::entry_mask_t set_mask;
  xbar_pkg::entry_mask_t clr_mask;
  xbar_pkg::entry_mask_t rd_ptr_oh;
  xbar_pkg::entry_mask_t pick_oh;
  xbar_pkg::entry_id_t   pick_id;

  //------------------------------------------------------------
  // oldest valid entry, scanning up from the read pointer
  //------------------------------------------------------------
  always_comb begin
    int  idx;
    logic found;
    pick_id = '0;
    found   = 1'b0;
    for (int i = 0; i < xbar_pkg::NUM_ENTRIES; i++) begin
      idx = int'(rd_ptr_i) + i;
      if (idx >= xbar_pkg::NUM_ENTRIES) begin
        idx = idx - xbar_pkg::NUM_ENTRIES;  // wrap
      end
      if (!found && valid_q[idx]) begin
        found   = 1'b1;
        pick_id = xbar_pkg::entry_id_t'(idx);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < xbar_pkg::NUM_ENTRIES; i++) begin
      pick_oh[i]   = (pick_id == xbar_pkg::entry_id_t'(i));
      rd_ptr_oh[i] = (rd_ptr_i == xbar_pkg::entry_id_t'(i));
    end
  end

  //------------------------------------------------------------
  // valid array
  //------------------------------------------------------------
  assign set_mask = alloc_i ? wr_ptr_oh_i : '0;
  assign clr_mask = gnt_i ? pick_oh : '0;
  assign valid_d  = (valid_q & ~clr_mask) | set_mask;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  //------------------------------------------------------------
  // bank outputs
  //------------------------------------------------------------
  assign req_o  = |valid_q;
  assign op_o   = ent_op_i[pick_id];
  assign addr_o = ent_addr_i[pick_id];

  assign head_valid_o = |(valid_q & rd_ptr_oh);  // blocks retirement

  // bank may only grant what is being offered
  a_gnt_needs_req : assert property (
    @(posedge clk_i) disable iff (rst_i)
    gnt_i |-> req_o
  );

endmodule

//--- hdl/ch_retire_ctrl.sv
`timescale 1ns/10ps

module ch_retire_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            accept_i,
  input  logic [xbar_pkg::NUM_BANKS-1:0]  head_valid_i,
  output xbar_pkg::entry_id_t             rd_ptr_o,
  output logic                            ready_o
);

  xbar_pkg::entry_id_t              rd_ptr_q;
  logic [xbar_pkg::ENTRY_ID_W-1:0]  used_q;
  logic                             retire;

  //------------------------------------------------------------
  // read pointer
  //------------------------------------------------------------
  // head is free once no bank still holds it
  assign retire = (used_q != '0) & ~|head_valid_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
    end else if (retire) begin
      if (rd_ptr_q == xbar_pkg::entry_id_t'(xbar_pkg::NUM_ENTRIES - 1)) begin
        rd_ptr_q <= '0;
      end else begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  //------------------------------------------------------------
  // used-entry count
  //------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      used_q <= '0;
    end else if (accept_i && !retire) begin
      used_q <= used_q + 1'b1;
    end else if (!accept_i && retire) begin
      used_q <= used_q - 1'b1;
    end
  end

  assign rd_ptr_o = rd_ptr_q;
  assign ready_o  = (used_q < xbar_pkg::NUM_ENTRIES);

  a_count_bounded : assert property (
    @(posedge clk_i) disable iff (rst_i)
    used_q <= xbar_pkg::NUM_ENTRIES
  );

endmodule

//--- hdl/ch_req_buffer.sv
`timescale 1ns/10ps

module ch_req_buffer (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  logic                                            req_valid_i,
  input  xbar_pkg::op_t                                   req_op_i,
  input  xbar_pkg::line_addr_t                            req_addr_i,
  output logic                                            req_ready_o,
  output logic                 [xbar_pkg::NUM_BANKS-1:0]  bank_req_o,
  output xbar_pkg::op_t        [xbar_pkg::NUM_BANKS-1:0]  bank_op_o,
  output xbar_pkg::line_addr_t [xbar_pkg::NUM_BANKS-1:0]  bank_addr_o,
  input  logic                 [xbar_pkg::NUM_BANKS-1:0]  bank_gnt_i
);

  logic                                               accept;
  logic                                               ready;
  logic [xbar_pkg::NUM_BANKS-1:0]                     alloc;
  logic [xbar_pkg::NUM_BANKS-1:0]                     head_valid;
  xbar_pkg::entry_mask_t                              wr_ptr_oh;
  xbar_pkg::entry_id_t                                rd_ptr;
  xbar_pkg::op_t        [xbar_pkg::NUM_ENTRIES-1:0]   ent_op;
  xbar_pkg::line_addr_t [xbar_pkg::NUM_ENTRIES-1:0]   ent_addr;

  ch_entry_store u_store (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .ready_i     (ready),
    .accept_o    (accept),
    .alloc_o     (alloc),
    .wr_ptr_oh_o (wr_ptr_oh),
    .ent_op_o    (ent_op),
    .ent_addr_o  (ent_addr)
  );

  //------------------------------------------------------------
  // one lane per bank
  //------------------------------------------------------------
  for (genvar b = 0; b < xbar_pkg::NUM_BANKS; b++) begin : g_lane
    ch_bank_lane u_lane (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .alloc_i      (alloc[b]),
      .wr_ptr_oh_i  (wr_ptr_oh),
      .rd_ptr_i     (rd_ptr),
      .ent_op_i     (ent_op),
      .ent_addr_i   (ent_addr),
      .gnt_i        (bank_gnt_i[b]),
      .req_o        (bank_req_o[b]),
      .op_o         (bank_op_o[b]),
      .addr_o       (bank_addr_o[b]),
      .head_valid_o (head_valid[b])
    );
  end

  ch_retire_ctrl u_retire (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .accept_i     (accept),
    .head_valid_i (head_valid),
    .rd_ptr_o     (rd_ptr),
    .ready_o      (ready)
  );

  assign req_ready_o = ready;

endmodule

//--- sim/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: test name, op, line address (byte address bits 31..4), grant delay
// bank is line address bits 5..4; mixed rows give the upper bound of a random delay

localparam int STEER_FIRST = 0;
localparam int ORDER_FIRST = 4;
localparam int BP_FIRST    = 9;
localparam int MIXED_FIRST = 15;
localparam int NUM_VECS    = 39;

function automatic void load_vectors();
  // one request per bank
  add_vec("steer_b0", 2'd0, 28'h00a1c05, 0);
  add_vec("steer_b1", 2'd1, 28'h00a1c1a, 0);
  add_vec("steer_b2", 2'd2, 28'h3ff0e2f, 0);
  add_vec("steer_b3", 2'd3, 28'h0123b31, 0);
  // banks 2 0 2 2 0, grants held until all five are in
  add_vec("order_0", 2'd1, 28'h0400020, 0);
  add_vec("order_1", 2'd2, 28'h0400041, 1);
  add_vec("order_2", 2'd3, 28'h04000a2, 0);
  add_vec("order_3", 2'd0, 28'h0400063, 2);
  add_vec("order_4", 2'd1, 28'h04000c4, 0);
  // oldest entry on bank 0, sixth request waits for space
  add_vec("bp_0", 2'd2, 28'h0bad001, 0);
  add_vec("bp_1", 2'd3, 28'h0bad012, 0);
  add_vec("bp_2", 2'd0, 28'h0bad023, 0);
  add_vec("bp_3", 2'd1, 28'h0bad0f4, 0);
  add_vec("bp_4", 2'd2, 28'h0bad055, 0);
  add_vec("bp_5", 2'd3, 28'h0bad0e6, 0);
  // mixed traffic
  add_vec("mix_00", 2'd2, 28'h1a2b3c1, 3);
  add_vec("mix_01", 2'd0, 28'h0001012, 5);
  add_vec("mix_02", 2'd3, 28'h7f00e23, 2);
  add_vec("mix_03", 2'd1, 28'h5555531, 6);
  add_vec("mix_04", 2'd1, 28'h000fd74, 1);
  add_vec("mix_05", 2'd2, 28'h0c0ff95, 4);
  add_vec("mix_06", 2'd3, 28'h0deadb6, 0);
  add_vec("mix_07", 2'd0, 28'h0beef87, 6);
  add_vec("mix_08", 2'd2, 28'h0012348, 2);
  add_vec("mix_09", 2'd1, 28'h0abcd69, 3);
  add_vec("mix_10", 2'd0, 28'h0f0f0aa, 5);
  add_vec("mix_11", 2'd3, 28'h0777711, 1);
  add_vec("mix_12", 2'd2, 28'h09999ee, 4);
  add_vec("mix_13", 2'd1, 28'h0246830, 2);
  add_vec("mix_14", 2'd0, 28'h0135759, 6);
  add_vec("mix_15", 2'd3, 28'h0fedcf2, 0);
  add_vec("mix_16", 2'd1, 28'h0300003, 3);
  add_vec("mix_17", 2'd2, 28'h0300124, 5);
  add_vec("mix_18", 2'd0, 28'h0300d15, 2);
  add_vec("mix_19", 2'd3, 28'h03001c6, 4);
  add_vec("mix_20", 2'd2, 28'h0400b37, 1);
  add_vec("mix_21", 2'd1, 28'h04002d8, 6);
  add_vec("mix_22", 2'd0, 28'h0400e69, 0);
  add_vec("mix_23", 2'd3, 28'h0400f0a, 3);
endfunction

`endif

//--- sim/tb_ch_req_buffer.sv
`timescale 1ns/10ps

module tb_ch_req_buffer;

  localparam int SEED          = 93879;
  localparam int RESET_CYCLES  = 16;
  localparam int READY_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 400;
  localparam int RUN_LIMIT     = 20000;  // cycles for the whole run
  localparam int NB            = xbar_pkg::NUM_BANKS;

  logic                           clk;
  logic                           rst;
  logic                           req_valid;
  xbar_pkg::op_t                  req_op;
  xbar_pkg::line_addr_t           req_addr;
  logic                           req_ready;
  logic                 [NB-1:0]  bank_req;
  xbar_pkg::op_t        [NB-1:0]  bank_op;
  xbar_pkg::line_addr_t [NB-1:0]  bank_addr;
  logic                 [NB-1:0]  bank_gnt;
  logic                 [NB-1:0]  gnt_enable;

  string                vec_name[$];
  xbar_pkg::op_t        vec_op[$];
  xbar_pkg::line_addr_t vec_addr[$];
  int                   vec_delay[$];

  int exp_q[NB][$];  // table row of each accepted request, per bank
  int dly_q[NB][$];  // grant delay of each accepted request
  int hold_cnt[NB];

  int err_cnt;
  int gnt_err_cnt;
  int tmo_cnt;
  int acc_cnt;
  int gnt_cnt;

  `include "tb_vectors.svh"

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  ch_req_buffer dut0 (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_valid_i (req_valid),
    .req_op_i    (req_op),
    .req_addr_i  (req_addr),
    .req_ready_o (req_ready),
    .bank_req_o  (bank_req),
    .bank_op_o   (bank_op),
    .bank_addr_o (bank_addr),
    .bank_gnt_i  (bank_gnt)
  );

  //------------------------------------------------------------
  // helpers
  //------------------------------------------------------------
  function automatic void add_vec(string name, xbar_pkg::op_t op,
                                  xbar_pkg::line_addr_t addr, int delay);
    vec_name.push_back(name);
    vec_op.push_back(op);
    vec_addr.push_back(addr);
    vec_delay.push_back(delay);
  endfunction

  // byte address bits 9..8 are line address bits 5..4
  function automatic int bank_of(xbar_pkg::line_addr_t addr);
    return int'(addr[5:4]);
  endfunction

  function automatic bit queues_empty();
    bit empty;
    empty = 1'b1;
    for (int b = 0; b < NB; b++) begin
      if (exp_q[b].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  function automatic bit buffer_idle();
    return (bank_req == '0 && req_ready === 1'b1 && queues_empty());
  endfunction

  task automatic finish_run();
    $display("summary: accepted %0d, granted %0d, errors %0d, timeouts %0d",
             acc_cnt, gnt_cnt, err_cnt + gnt_err_cnt, tmo_cnt);
    if (err_cnt + gnt_err_cnt + tmo_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic abort_run(string what);
    tmo_cnt++;
    $display("TIMEOUT: %s", what);
    finish_run();
  endtask

  task automatic present_req(int i);
    req_valid = 1'b1;
    req_op    = vec_op[i];
    req_addr  = vec_addr[i];
  endtask

  // ready only follows state, so a high sample here means acceptance at the next edge
  task automatic complete_req(int i, int delay);
    int n;
    n = 0;
    while (req_ready !== 1'b1 && n < READY_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (req_ready !== 1'b1) begin
      abort_run($sformatf("request %s was never accepted", vec_name[i]));
    end else begin
      exp_q[bank_of(vec_addr[i])].push_back(i);
      dly_q[bank_of(vec_addr[i])].push_back(delay);
      acc_cnt++;
      @(negedge clk);
      req_valid = 1'b0;
    end
  endtask

  task automatic send_req(int i, int delay);
    present_req(i);
    complete_req(i, delay);
  endtask

  task automatic wait_drain(string what);
    int n;
    n = 0;
    while (!buffer_idle() && n < DRAIN_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!buffer_idle()) begin
      abort_run($sformatf("buffer did not drain after %s", what));
    end else begin
      repeat (xbar_pkg::NUM_ENTRIES + 1) @(negedge clk);  // one retire per clock
    end
  endtask

  function automatic void check_grant(int b);
    int i;
    i = exp_q[b].pop_front();
    void'(dly_q[b].pop_front());
    gnt_cnt++;
    if (bank_op[b] !== vec_op[i]) begin
      gnt_err_cnt++;
      $display("ERROR %s: bank %0d op expected %0h actual %0h",
               vec_name[i], b, vec_op[i], bank_op[b]);
    end
    if (bank_addr[b] !== vec_addr[i]) begin
      gnt_err_cnt++;
      $display("ERROR %s: bank %0d addr expected %07h actual %07h",
               vec_name[i], b, vec_addr[i], bank_addr[b]);
    end
  endfunction

  //------------------------------------------------------------
  // bank side, one grant decision per bank each cycle
  //------------------------------------------------------------
  initial begin : bank_server
    int            cyc;
    logic [NB-1:0] gnt_next;
    cyc      = 0;
    bank_gnt = '0;
    for (int b = 0; b < NB; b++) begin
      hold_cnt[b] = 0;
    end
    while (cyc < RUN_LIMIT) begin
      @(negedge clk);
      cyc++;
      gnt_next = '0;
      for (int b = 0; b < NB; b++) begin
        if (!rst && bank_req[b] && exp_q[b].size() == 0) begin
          gnt_err_cnt++;
          $display("bank %0d raised its request with nothing pending", b);
        end else if (!rst && bank_req[b] && gnt_enable[b]) begin
          if (hold_cnt[b] >= dly_q[b][0]) begin
            check_grant(b);
            gnt_next[b] = 1'b1;
            hold_cnt[b] = 0;
          end else begin
            hold_cnt[b]++;
          end
        end
      end
      bank_gnt = gnt_next;
    end
    abort_run("run exceeded its cycle limit");
  end

  //------------------------------------------------------------
  // master side and sequence
  //------------------------------------------------------------
  initial begin : main_seq
    logic [NB-1:0] exp_mask;
    int            b;
    int            i;
    void'($urandom(SEED));
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_op     = '0;
    req_addr   = '0;
    gnt_enable = '0;
    load_vectors();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    if (req_ready !== 1'b1) begin
      err_cnt++;
      $display("ERROR reset: req_ready expected 1 actual %b", req_ready);
    end
    if (bank_req !== '0) begin
      err_cnt++;
      $display("ERROR reset: bank_req expected 0000 actual %b", bank_req);
    end

    // steering, one bank at a time
    for (i = STEER_FIRST; i < ORDER_FIRST; i++) begin
      gnt_enable = '0;
      b = bank_of(vec_addr[i]);
      send_req(i, vec_delay[i]);
      exp_mask    = '0;
      exp_mask[b] = 1'b1;
      if (bank_req !== exp_mask) begin
        err_cnt++;
        $display("ERROR %s: bank_req expected %b actual %b", vec_name[i], exp_mask, bank_req);
      end
      if (bank_op[b] !== vec_op[i]) begin
        err_cnt++;
        $display("ERROR %s: op expected %0h actual %0h", vec_name[i], vec_op[i], bank_op[b]);
      end
      if (bank_addr[b] !== vec_addr[i]) begin
        err_cnt++;
        $display("ERROR %s: addr expected %07h actual %07h",
                 vec_name[i], vec_addr[i], bank_addr[b]);
      end
      gnt_enable = '1;
      wait_drain(vec_name[i]);
    end

    // per-bank order, grants released after the buffer fills
    gnt_enable = '0;
    for (i = ORDER_FIRST; i < BP_FIRST; i++) begin
      send_req(i, vec_delay[i]);
    end
    if (req_ready !== 1'b0) begin
      err_cnt++;
      $display("ERROR order_full: req_ready expected 0 actual %b", req_ready);
    end
    gnt_enable = '1;
    wait_drain("order");

    // back-pressure
    gnt_enable = '0;
    for (i = BP_FIRST; i < BP_FIRST + xbar_pkg::NUM_ENTRIES; i++) begin
      send_req(i, vec_delay[i]);
    end
    i = BP_FIRST + xbar_pkg::NUM_ENTRIES;
    present_req(i);
    repeat (8) begin
      @(negedge clk);
      if (req_ready !== 1'b0) begin
        err_cnt++;
        $display("ERROR bp_hold: req_ready expected 0 actual %b", req_ready);
      end
    end
    // other banks drain, oldest entry still blocks storage
    gnt_enable = '1;
    gnt_enable[bank_of(vec_addr[BP_FIRST])] = 1'b0;
    repeat (12) begin
      @(negedge clk);
      if (req_ready !== 1'b0) begin
        err_cnt++;
        $display("ERROR bp_head: req_ready expected 0 actual %b", req_ready);
      end
    end
    gnt_enable = '1;
    complete_req(i, vec_delay[i]);
    wait_drain("bp");

    // mixed traffic with random gaps and grant delays
    for (i = MIXED_FIRST; i < NUM_VECS; i++) begin
      repeat ($urandom_range(2)) @(negedge clk);
      send_req(i, int'($urandom_range(vec_delay[i])));
    end
    wait_drain("mixed");
    finish_run();
  end

endmodule

//--- all.f
+incdir+sim
hdl/xbar_pkg.sv
hdl/ch_entry_store.sv
hdl/ch_bank_lane.sv
hdl/ch_retire_ctrl.sv
hdl/ch_req_buffer.sv
sim/tb_ch_req_buffer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the request buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/10ps \
  --top-module tb_ch_req_buffer \
  --Mdir "$OBJ" -o sim_tb \
  -f all.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '>>> FAIL' "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

exit 0
